/* hw/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	// pre-decode word bit positions
	localparam int PDC_IS_REM       = 0;
	localparam int PDC_IS_DIV       = 1;
	localparam int PDC_IS_MUL       = 2;
	localparam int PDC_IS_STORE     = 3;
	localparam int PDC_IS_LOAD      = 4;
	localparam int PDC_IS_CSR       = 5;
	localparam int PDC_IS_JALR      = 6;
	localparam int PDC_IS_JAL       = 7;
	localparam int PDC_IS_B         = 8;
	localparam int PDC_IS_ECALL     = 9;
	localparam int PDC_IS_MRET      = 10;
	localparam int PDC_IMM_SID      = 11; // 21-bit jump/branch offset
	localparam int PDC_RD_VLD       = 32;
	localparam int PDC_RS2_VLD      = 33;
	localparam int PDC_RS1_VLD      = 34;
	localparam int PDC_CSR_ADDR_SID = 35; // 12-bit csr address

	// instruction type flags
	localparam int TYPE_REM   = 0;
	localparam int TYPE_DIV   = 1;
	localparam int TYPE_MUL   = 2;
	localparam int TYPE_STORE = 3;
	localparam int TYPE_LOAD  = 4;
	localparam int TYPE_CSR   = 5;
	localparam int TYPE_B     = 6;
	localparam int TYPE_ECALL = 7;
	localparam int TYPE_MRET  = 8;

	// imem response codes from fetch
	localparam logic [1:0] IMEM_OK        = 2'b00;
	localparam logic [1:0] IMEM_UNALIGNED = 2'b01;
	localparam logic [1:0] IMEM_BUS_ERR   = 2'b10;
	localparam logic [1:0] IMEM_TIMEOUT   = 2'b11;

	localparam logic [2:0] ERR_NONE         = 3'b000;
	localparam logic [2:0] ERR_ILLEGAL      = 3'b001;
	localparam logic [2:0] ERR_PC_UNALIGNED = 3'b010;
	localparam logic [2:0] ERR_BUS          = 3'b011;
	localparam logic [2:0] ERR_LD_UNALIGNED = 3'b110;
	localparam logic [2:0] ERR_ST_UNALIGNED = 3'b111;

	// same values as the funct3 of loads
	localparam logic [2:0] LS_BYTE   = 3'b000;
	localparam logic [2:0] LS_HALF   = 3'b001;
	localparam logic [2:0] LS_WORD   = 3'b010;
	localparam logic [2:0] LS_BYTE_U = 3'b100;
	localparam logic [2:0] LS_HALF_U = 3'b101;

	localparam logic [3:0] ALU_ADD  = 4'd0;
	localparam logic [3:0] ALU_SUB  = 4'd1;
	localparam logic [3:0] ALU_SLL  = 4'd2;
	localparam logic [3:0] ALU_SLT  = 4'd3;
	localparam logic [3:0] ALU_SLTU = 4'd4;
	localparam logic [3:0] ALU_XOR  = 4'd5;
	localparam logic [3:0] ALU_SRL  = 4'd6;
	localparam logic [3:0] ALU_SRA  = 4'd7;
	localparam logic [3:0] ALU_OR   = 4'd8;
	localparam logic [3:0] ALU_AND  = 4'd9;

	// one 71-bit payload, read by instruction class
	typedef union packed {
		struct packed { logic [2:0] ls_type; logic [3:0] alu_mode;
			logic [31:0] op1; logic [31:0] op2; } ls;
		struct packed { logic [24:0] pad; logic [11:0] csr_addr;
			logic [1:0] upd_type; logic [31:0] mask; } csr;
		struct packed { logic [3:0] pad; logic [32:0] op_a;
			logic [32:0] op_b; logic res_sel; } md;
		struct packed { logic [38:0] pad; logic [31:0] inst; } ill;
		struct packed { logic [1:0] pad; logic prdt_jump; logic [3:0] alu_mode;
			logic [31:0] op1; logic [31:0] op2; } alu;
	} dispatch_payload_u;

endpackage

`default_nettype wire

/* hw/fetch_pre_decoder.sv */
`default_nettype none

module fetch_pre_decoder
	import decode_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        flush_req,
	input  logic [31:0] fetch_inst,
	input  logic [31:0] fetch_pc,
	input  logic        fetch_prdt_jump,
	input  logic [1:0]  fetch_imem_err,
	input  logic        fetch_valid,
	output logic        fetch_ready,
	output logic [31:0] pd_inst,
	output logic [31:0] pd_pc,
	output logic [63:0] pd_msg,
	output logic        pd_prdt_jump,
	output logic        pd_illegal,
	output logic [1:0]  pd_imem_err,
	output logic        pd_valid,
	input  logic        pd_ready
);
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [20:0] b_ofs;
	logic [20:0] j_ofs;
	logic [63:0] msg_d;
	logic        illegal_d;
	logic        fetch_fire;

	assign opcode = fetch_inst[6:0];
	assign funct3 = fetch_inst[14:12];
	assign funct7 = fetch_inst[31:25];
	// offsets already sign extended to 21 bits
	assign b_ofs = {{8{fetch_inst[31]}}, fetch_inst[31], fetch_inst[7], fetch_inst[30:25],
		fetch_inst[11:8], 1'b0};
	assign j_ofs = {fetch_inst[31], fetch_inst[19:12], fetch_inst[20], fetch_inst[30:21], 1'b0};

	always_comb
	begin
		msg_d = '0;
		illegal_d = 1'b0;
		case (opcode)
			7'b0110111, 7'b0010111: msg_d[PDC_RD_VLD] = 1'b1; // lui, auipc
			7'b1101111:
			begin
				msg_d[PDC_IS_JAL] = 1'b1;
				msg_d[PDC_RD_VLD] = 1'b1;
				msg_d[PDC_IMM_SID +: 21] = j_ofs;
			end
			7'b1100111:
			begin
				msg_d[PDC_IS_JALR] = 1'b1;
				msg_d[PDC_RD_VLD] = 1'b1;
				msg_d[PDC_RS1_VLD] = 1'b1;
				illegal_d = funct3 != 3'b000;
			end
			7'b1100011:
			begin
				msg_d[PDC_IS_B] = 1'b1;
				msg_d[PDC_RS1_VLD] = 1'b1;
				msg_d[PDC_RS2_VLD] = 1'b1;
				msg_d[PDC_IMM_SID +: 21] = b_ofs;
				illegal_d = funct3[2:1] == 2'b01; // no 010/011 branch
			end
			7'b0000011:
			begin
				msg_d[PDC_IS_LOAD] = 1'b1;
				msg_d[PDC_RD_VLD] = 1'b1;
				msg_d[PDC_RS1_VLD] = 1'b1;
				illegal_d = funct3 == 3'b011 || funct3[2:1] == 2'b11;
			end
			7'b0100011:
			begin
				msg_d[PDC_IS_STORE] = 1'b1;
				msg_d[PDC_RS1_VLD] = 1'b1;
				msg_d[PDC_RS2_VLD] = 1'b1;
				illegal_d = funct3[2] || funct3 == 3'b011; // sb/sh/sw only
			end
			7'b0010011:
			begin
				msg_d[PDC_RD_VLD] = 1'b1;
				msg_d[PDC_RS1_VLD] = 1'b1;
				// shift immediates keep funct7 clean, srai may set bit 30
				if (funct3 == 3'b001)
					illegal_d = funct7 != 7'b0000000;
				else if (funct3 == 3'b101)
					illegal_d = funct7 != 7'b0000000 && funct7 != 7'b0100000;
			end
			7'b0110011:
			begin
				msg_d[PDC_RD_VLD] = 1'b1;
				msg_d[PDC_RS1_VLD] = 1'b1;
				msg_d[PDC_RS2_VLD] = 1'b1;
				if (funct7 == 7'b0000001)
				begin
					msg_d[PDC_IS_MUL] = ~funct3[2];
					msg_d[PDC_IS_DIV] = funct3[2:1] == 2'b10;
					msg_d[PDC_IS_REM] = funct3[2:1] == 2'b11;
				end
				else if (funct7 == 7'b0100000)
					illegal_d = funct3 != 3'b000 && funct3 != 3'b101; // sub, sra
				else
					illegal_d = funct7 != 7'b0000000;
			end
			7'b0001111: ; // fence runs as a nop
			7'b1110011:
			begin
				if (funct3 == 3'b000)
				begin
					msg_d[PDC_IS_ECALL] = fetch_inst == 32'h0000_0073;
					msg_d[PDC_IS_MRET] = fetch_inst == 32'h3020_0073;
					illegal_d = ~msg_d[PDC_IS_ECALL] & ~msg_d[PDC_IS_MRET]; // ebreak, wfi
				end
				else
				begin
					msg_d[PDC_IS_CSR] = 1'b1;
					msg_d[PDC_RD_VLD] = 1'b1;
					msg_d[PDC_RS1_VLD] = ~funct3[2]; // csrr*i use the uimm field
					msg_d[PDC_CSR_ADDR_SID +: 12] = fetch_inst[31:20];
					illegal_d = funct3 == 3'b100;
				end
			end
			default: illegal_d = 1'b1;
		endcase
	end

	// one entry, refilled in the cycle it drains
	assign fetch_ready = (~pd_valid | pd_ready) & ~flush_req;
	assign fetch_fire = fetch_valid & fetch_ready;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			pd_valid <= 1'b0;
		else if (flush_req)
			pd_valid <= 1'b0;
		else if (fetch_ready)
			pd_valid <= fetch_valid;
	end

	always_ff @(posedge clk)
	begin
		if (fetch_fire)
		begin
			pd_inst <= fetch_inst;
			pd_pc <= fetch_pc;
			pd_msg <= msg_d;
			pd_prdt_jump <= fetch_prdt_jump;
			pd_illegal <= illegal_d;
			pd_imem_err <= fetch_imem_err;
		end
	end

endmodule

`default_nettype wire

/* hw/gpr_file.sv */
`default_nettype none

module gpr_file (
	input  logic        clk,
	input  logic        resetn,
	input  logic        flush_req,
	input  logic [4:0]  rd_req_rs1_id,
	input  logic [4:0]  rd_req_rs2_id,
	input  logic        rd_req_rs1_vld,
	input  logic        rd_req_rs2_vld,
	input  logic        rd_req_valid,
	output logic        rd_req_ready,
	output logic [31:0] rd_res_rs1_v,
	output logic [31:0] rd_res_rs2_v,
	output logic        rd_res_valid,
	input  logic        rd_res_ready,
	input  logic        wb_en,
	input  logic [4:0]  wb_rd_id,
	input  logic [31:0] wb_rd_v
);
	logic [31:0] regs [1:31]; // no storage behind x0
	logic        req_fire;

	// x0 and unused sources give zero
	function automatic logic [31:0] read_src(input logic [4:0] id, input logic vld);
		read_src = (vld && id != 5'd0) ? regs[id] : 32'd0;
	endfunction

	always_ff @(posedge clk)
	begin
		if (wb_en && wb_rd_id != 5'd0)
			regs[wb_rd_id] <= wb_rd_v;
	end

	assign rd_req_ready = (~rd_res_valid | rd_res_ready) & ~flush_req;
	assign req_fire = rd_req_valid & rd_req_ready;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			rd_res_valid <= 1'b0;
		else if (flush_req)
			rd_res_valid <= 1'b0;
		else if (rd_req_ready)
			rd_res_valid <= rd_req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (req_fire)
		begin
			rd_res_rs1_v <= read_src(rd_req_rs1_id, rd_req_rs1_vld);
			rd_res_rs2_v <= read_src(rd_req_rs2_id, rd_req_rs2_vld);
		end
	end

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
`default_nettype none

module inst_decoder
	import decode_pkg::*;
(
	input  logic [31:0] inst,
	input  logic [63:0] pd_msg,
	input  logic [31:0] pc,
	input  logic        prdt_jump,
	input  logic [31:0] rs1_v,
	input  logic [31:0] rs2_v,
	output logic [8:0]  inst_type,
	output logic [3:0]  alu_mode,
	output logic [31:0] alu_op1,
	output logic [31:0] alu_op2,
	output logic [2:0]  ls_type,
	output logic        ls_addr_aligned,
	output logic [1:0]  csr_upd_type,
	output logic [31:0] csr_mask,
	output logic [32:0] md_op_a,
	output logic [32:0] md_op_b,
	output logic        md_res_sel,
	output logic [31:0] brc_pc_upd
);
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] u_imm;
	logic [31:0] jmp_ofs;
	logic [31:0] pc_plus4;
	logic [31:0] jalr_tgt;
	logic [31:0] ls_addr;
	logic        a_signed;
	logic        b_signed;

	// funct3 to alu op, alt picks sub/sra
	function automatic logic [3:0] alu_mode_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_mode_of = alt ? ALU_SUB : ALU_ADD;
			3'b001: alu_mode_of = ALU_SLL;
			3'b010: alu_mode_of = ALU_SLT;
			3'b011: alu_mode_of = ALU_SLTU;
			3'b100: alu_mode_of = ALU_XOR;
			3'b101: alu_mode_of = alt ? ALU_SRA : ALU_SRL;
			3'b110: alu_mode_of = ALU_OR;
			3'b111: alu_mode_of = ALU_AND;
		endcase
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign u_imm = {inst[31:12], 12'd0};
	assign jmp_ofs = {{11{pd_msg[PDC_IMM_SID + 20]}}, pd_msg[PDC_IMM_SID +: 21]};
	assign pc_plus4 = pc + 32'd4;

	// class flags straight from pre-decode
	assign inst_type[TYPE_REM] = pd_msg[PDC_IS_REM];
	assign inst_type[TYPE_DIV] = pd_msg[PDC_IS_DIV];
	assign inst_type[TYPE_MUL] = pd_msg[PDC_IS_MUL];
	assign inst_type[TYPE_STORE] = pd_msg[PDC_IS_STORE];
	assign inst_type[TYPE_LOAD] = pd_msg[PDC_IS_LOAD];
	assign inst_type[TYPE_CSR] = pd_msg[PDC_IS_CSR];
	assign inst_type[TYPE_B] = pd_msg[PDC_IS_B];
	assign inst_type[TYPE_ECALL] = pd_msg[PDC_IS_ECALL];
	assign inst_type[TYPE_MRET] = pd_msg[PDC_IS_MRET];

	always_comb
	begin
		alu_mode = ALU_ADD;
		alu_op1 = rs1_v;
		alu_op2 = rs2_v;
		if (pd_msg[PDC_IS_LOAD] | pd_msg[PDC_IS_STORE])
			alu_op2 = pd_msg[PDC_IS_STORE] ? s_imm : i_imm; // address add
		else if (pd_msg[PDC_IS_B])
			alu_mode = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_XOR;
		else if (pd_msg[PDC_IS_JAL] | pd_msg[PDC_IS_JALR])
		begin
			alu_op1 = pc; // link value
			alu_op2 = 32'd4;
		end
		else
		begin
			case (opcode)
				7'b0110111:
				begin
					alu_op1 = 32'd0; // lui
					alu_op2 = u_imm;
				end
				7'b0010111:
				begin
					alu_op1 = pc; // auipc
					alu_op2 = u_imm;
				end
				7'b0010011:
				begin
					alu_mode = alu_mode_of(funct3, funct3 == 3'b101 && inst[30]);
					// shamt only for shifts
					alu_op2 = (funct3[1:0] == 2'b01) ? {27'd0, inst[24:20]} : i_imm;
				end
				7'b0110011: alu_mode = alu_mode_of(funct3, inst[30]);
				default: ;
			endcase
		end
	end

	always_comb
	begin
		case (funct3)
			3'b000: ls_type = LS_BYTE;
			3'b001: ls_type = LS_HALF;
			3'b100: ls_type = LS_BYTE_U;
			3'b101: ls_type = LS_HALF_U;
			default: ls_type = LS_WORD;
		endcase
	end

	assign ls_addr = rs1_v + (pd_msg[PDC_IS_STORE] ? s_imm : i_imm);
	assign ls_addr_aligned = (funct3[1:0] == 2'b01) ? ~ls_addr[0] :
		(funct3[1:0] == 2'b10) ? (ls_addr[1:0] == 2'b00) : 1'b1; // bytes always fit

	// 01 write, 10 set, 11 clear
	assign csr_upd_type = funct3[1:0];
	assign csr_mask = funct3[2] ? {27'd0, inst[19:15]} : rs1_v;

	// mulhu, divu, remu are unsigned on both sides, mulhsu only on b
	assign a_signed = funct3[2] ? ~funct3[0] : (funct3[1:0] != 2'b11);
	assign b_signed = funct3[2] ? ~funct3[0] : ~funct3[1];
	assign md_op_a = {a_signed & rs1_v[31], rs1_v};
	assign md_op_b = {b_signed & rs2_v[31], rs2_v};
	assign md_res_sel = ~funct3[2] & (funct3[1:0] != 2'b00); // mulh*

	assign jalr_tgt = rs1_v + i_imm;
	// predicted taken means correction falls through
	assign brc_pc_upd = prdt_jump ? pc_plus4 :
		pd_msg[PDC_IS_JALR] ? {jalr_tgt[31:1], 1'b0} : pc + jmp_ofs;

endmodule

`default_nettype wire

/* hw/dispatch_msg_gen.sv */
`default_nettype none

module dispatch_msg_gen
	import decode_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,
	input  logic              flush_req,
	input  logic [31:0]       pd_inst,
	input  logic [31:0]       pd_pc,
	input  logic [63:0]       pd_msg,
	input  logic              pd_prdt_jump,
	input  logic              pd_illegal,
	input  logic [1:0]        pd_imem_err,
	input  logic              pd_valid,
	output logic              pd_ready,
	output logic [4:0]        rd_req_rs1_id,
	output logic [4:0]        rd_req_rs2_id,
	output logic              rd_req_rs1_vld,
	output logic              rd_req_rs2_vld,
	output logic              rd_req_valid,
	input  logic              rd_req_ready,
	input  logic [31:0]       rd_res_rs1_v,
	input  logic [31:0]       rd_res_rs2_v,
	input  logic              rd_res_valid,
	output logic              rd_res_ready,
	output dispatch_payload_u disp_payload,
	output logic [8:0]        disp_inst_type,
	output logic [31:0]       disp_pc,
	output logic [31:0]       disp_brc_pc_upd_store_din,
	output logic [4:0]        disp_rd_id,
	output logic              disp_rd_vld,
	output logic [2:0]        disp_err_code,
	output logic              disp_valid,
	input  logic              disp_ready
);
	logic              suppress; // request sent, result not yet taken
	logic              disp_free;
	logic              res_fire;
	logic [8:0]        inst_type;
	logic [3:0]        alu_mode;
	logic [31:0]       alu_op1;
	logic [31:0]       alu_op2;
	logic [2:0]        ls_type;
	logic              ls_addr_aligned;
	logic [1:0]        csr_upd_type;
	logic [31:0]       csr_mask;
	logic [32:0]       md_op_a;
	logic [32:0]       md_op_b;
	logic              md_res_sel;
	logic [31:0]       brc_pc_upd;
	dispatch_payload_u payload_d;
	logic [2:0]        err_d;

	assign disp_free = ~disp_valid | disp_ready;

	// entry and result leave together
	assign rd_req_valid = pd_valid & ~suppress & ~flush_req;
	assign pd_ready = rd_res_valid & disp_free & ~flush_req;
	assign rd_res_ready = pd_valid & disp_free & ~flush_req;
	assign res_fire = rd_res_valid & rd_res_ready;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			suppress <= 1'b0;
		else
			suppress <= ~flush_req & (suppress | (rd_req_valid & rd_req_ready)) & ~res_fire;
	end

	// illegal words read nothing
	assign rd_req_rs1_id = pd_inst[19:15];
	assign rd_req_rs2_id = pd_inst[24:20];
	assign rd_req_rs1_vld = pd_msg[PDC_RS1_VLD] & ~pd_illegal;
	assign rd_req_rs2_vld = pd_msg[PDC_RS2_VLD] & ~pd_illegal;

	inst_decoder u_dec (
		.inst            (pd_inst),
		.pd_msg          (pd_msg),
		.pc              (pd_pc),
		.prdt_jump       (pd_prdt_jump),
		.rs1_v           (rd_res_rs1_v),
		.rs2_v           (rd_res_rs2_v),
		.inst_type       (inst_type),
		.alu_mode        (alu_mode),
		.alu_op1         (alu_op1),
		.alu_op2         (alu_op2),
		.ls_type         (ls_type),
		.ls_addr_aligned (ls_addr_aligned),
		.csr_upd_type    (csr_upd_type),
		.csr_mask        (csr_mask),
		.md_op_a         (md_op_a),
		.md_op_b         (md_op_b),
		.md_res_sel      (md_res_sel),
		.brc_pc_upd      (brc_pc_upd)
	);

	// payload view by class, illegal wins
	always_comb
	begin
		payload_d = '0;
		if (pd_illegal)
			payload_d.ill.inst = pd_inst;
		else if (inst_type[TYPE_LOAD] | inst_type[TYPE_STORE])
		begin
			payload_d.ls.ls_type = ls_type;
			payload_d.ls.alu_mode = alu_mode;
			payload_d.ls.op1 = alu_op1;
			payload_d.ls.op2 = alu_op2;
		end
		else if (inst_type[TYPE_CSR])
		begin
			payload_d.csr.csr_addr = pd_msg[PDC_CSR_ADDR_SID +: 12];
			payload_d.csr.upd_type = csr_upd_type;
			payload_d.csr.mask = csr_mask;
		end
		else if (inst_type[TYPE_MUL] | inst_type[TYPE_DIV] | inst_type[TYPE_REM])
		begin
			payload_d.md.op_a = md_op_a;
			payload_d.md.op_b = md_op_b;
			payload_d.md.res_sel = md_res_sel;
		end
		else
		begin
			payload_d.alu.prdt_jump = pd_prdt_jump;
			payload_d.alu.alu_mode = alu_mode;
			payload_d.alu.op1 = alu_op1;
			payload_d.alu.op2 = alu_op2;
		end
	end

	// illegal, then fetch error, then misaligned access
	always_comb
	begin
		err_d = ERR_NONE;
		if (pd_illegal)
			err_d = ERR_ILLEGAL;
		else
		begin
			case (pd_imem_err)
				IMEM_OK:
				begin
					if (inst_type[TYPE_LOAD] & ~ls_addr_aligned)
						err_d = ERR_LD_UNALIGNED;
					else if (inst_type[TYPE_STORE] & ~ls_addr_aligned)
						err_d = ERR_ST_UNALIGNED;
				end
				IMEM_UNALIGNED: err_d = ERR_PC_UNALIGNED;
				IMEM_BUS_ERR, IMEM_TIMEOUT: err_d = ERR_BUS;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (~resetn)
			disp_valid <= 1'b0;
		else if (flush_req)
			disp_valid <= 1'b0;
		else if (disp_free)
			disp_valid <= res_fire;
	end

	always_ff @(posedge clk)
	begin
		if (res_fire)
		begin
			disp_payload <= payload_d;
			disp_inst_type <= pd_illegal ? 9'd0 : inst_type;
			disp_pc <= pd_pc;
			disp_brc_pc_upd_store_din <= inst_type[TYPE_STORE] ? rd_res_rs2_v : brc_pc_upd;
			disp_rd_id <= pd_inst[11:7];
			disp_rd_vld <= pd_msg[PDC_RD_VLD] & ~pd_illegal;
			disp_err_code <= err_d;
		end
	end

endmodule

`default_nettype wire

/* hw/decode_stage_top.sv */
`default_nettype none

module decode_stage_top
	import decode_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,
	input  logic              flush_req,
	input  logic [31:0]       fetch_inst,
	input  logic [31:0]       fetch_pc,
	input  logic              fetch_prdt_jump,
	input  logic [1:0]        fetch_imem_err,
	input  logic              fetch_valid,
	output logic              fetch_ready,
	input  logic              wb_en,
	input  logic [4:0]        wb_rd_id,
	input  logic [31:0]       wb_rd_v,
	output dispatch_payload_u disp_payload,
	output logic [8:0]        disp_inst_type,
	output logic [31:0]       disp_pc,
	output logic [31:0]       disp_brc_pc_upd_store_din,
	output logic [4:0]        disp_rd_id,
	output logic              disp_rd_vld,
	output logic [2:0]        disp_err_code,
	output logic              disp_valid,
	input  logic              disp_ready
);
	// pre-decoded entry
	logic [31:0] pd_inst;
	logic [31:0] pd_pc;
	logic [63:0] pd_msg;
	logic        pd_prdt_jump;
	logic        pd_illegal;
	logic [1:0]  pd_imem_err;
	logic        pd_valid;
	logic        pd_ready;
	// register read request and result
	logic [4:0]  rs1_id;
	logic [4:0]  rs2_id;
	logic        rs1_vld;
	logic        rs2_vld;
	logic        req_valid;
	logic        req_ready;
	logic [31:0] rs1_v;
	logic [31:0] rs2_v;
	logic        res_valid;
	logic        res_ready;

	fetch_pre_decoder u_pdc (
		.clk, .resetn, .flush_req,
		.fetch_inst, .fetch_pc, .fetch_prdt_jump, .fetch_imem_err, .fetch_valid, .fetch_ready,
		.pd_inst, .pd_pc, .pd_msg, .pd_prdt_jump, .pd_illegal, .pd_imem_err, .pd_valid,
		.pd_ready
	);

	gpr_file u_gpr (
		.clk, .resetn, .flush_req,
		.rd_req_rs1_id (rs1_id),
		.rd_req_rs2_id (rs2_id),
		.rd_req_rs1_vld (rs1_vld),
		.rd_req_rs2_vld (rs2_vld),
		.rd_req_valid  (req_valid),
		.rd_req_ready  (req_ready),
		.rd_res_rs1_v  (rs1_v),
		.rd_res_rs2_v  (rs2_v),
		.rd_res_valid  (res_valid),
		.rd_res_ready  (res_ready),
		.wb_en, .wb_rd_id, .wb_rd_v
	);

	dispatch_msg_gen u_disp (
		.clk, .resetn, .flush_req,
		.pd_inst, .pd_pc, .pd_msg, .pd_prdt_jump, .pd_illegal, .pd_imem_err, .pd_valid,
		.pd_ready,
		.rd_req_rs1_id (rs1_id),
		.rd_req_rs2_id (rs2_id),
		.rd_req_rs1_vld (rs1_vld),
		.rd_req_rs2_vld (rs2_vld),
		.rd_req_valid  (req_valid),
		.rd_req_ready  (req_ready),
		.rd_res_rs1_v  (rs1_v),
		.rd_res_rs2_v  (rs2_v),
		.rd_res_valid  (res_valid),
		.rd_res_ready  (res_ready),
		.disp_payload, .disp_inst_type, .disp_pc, .disp_brc_pc_upd_store_din,
		.disp_rd_id, .disp_rd_vld, .disp_err_code, .disp_valid, .disp_ready
	);

endmodule

`default_nettype wire

/* tests/tb_decode_stage.sv */
`default_nettype none

module tb_decode_stage
	import decode_pkg::*;
;
	localparam int N_ITEMS = 170;
	localparam int CYCLE_LIMIT = 4000;
	localparam int FLUSH_A = 80;
	localparam int FLUSH_B = 200;

	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		logic        pj;
		logic [1:0]  err;
	} stim_t;

	typedef struct packed {
		dispatch_payload_u pl;
		logic [8:0]  itype;
		logic [31:0] pc;
		logic [31:0] brc;
		logic        chk_brc; // brc only defined for jumps, branches, stores
		logic [4:0]  rd_id;
		logic        rd_vld;
		logic [2:0]  err;
	} exp_t;

	logic clk = 1'b0;
	logic resetn;
	logic flush_req;
	logic [31:0] fetch_inst;
	logic [31:0] fetch_pc;
	logic fetch_prdt_jump;
	logic [1:0] fetch_imem_err;
	logic fetch_valid;
	logic fetch_ready;
	logic wb_en;
	logic [4:0] wb_rd_id;
	logic [31:0] wb_rd_v;
	dispatch_payload_u disp_payload;
	logic [8:0] disp_inst_type;
	logic [31:0] disp_pc;
	logic [31:0] disp_brc_pc_upd_store_din;
	logic [4:0] disp_rd_id;
	logic disp_rd_vld;
	logic [2:0] disp_err_code;
	logic disp_valid;
	logic disp_ready;

	logic [15:0] lfsr_state = 16'd58214;
	logic [31:0] model_regs [0:31];
	stim_t stim_q[$];
	exp_t pend_q[$]; // expected messages not yet fetched
	exp_t exp_q[$]; // fetched and awaiting dispatch

	always #10 clk = ~clk;

	decode_stage_top dut (.*);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [31:0] reg_val(input logic [4:0] id);
		reg_val = (id == 5'd0) ? 32'd0 : model_regs[id];
	endfunction

	task automatic check_field(input string name, input logic [159:0] got,
		input logic [159:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	// encode one instruction of the given kind and derive its message
	task automatic make_item(input int kind, input int idx);
		stim_t s;
		exp_t e;
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [11:0] i12;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] ofs;
		logic [31:0] addr;
		logic [3:0] mode;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [2:0] lst;
		logic res_sel;
		logic mis;
		int cls; // 0 alu, 1 ls, 2 csr, 3 md, 4 illegal
		rand_bits(5, r);
		rd = r[4:0];
		rand_bits(5, r);
		rs1 = (idx % 10 == 3) ? 5'd0 : r[4:0]; // x0 source now and then
		rand_bits(5, r);
		rs2 = r[4:0];
		rand_bits(12, r);
		i12 = r[11:0];
		rand_bits(1, r);
		s.pj = r[0];
		rand_bits(2, r);
		s.err = (idx % 6 == 5) ? r[1:0] : IMEM_OK;
		s.pc = 32'h0000_1000 + idx * 4;
		a = reg_val(rs1);
		b = reg_val(rs2);
		imm = {{20{i12[11]}}, i12};
		e = '0;
		e.pc = s.pc;
		e.rd_id = rd;
		mode = ALU_ADD;
		op1 = a;
		op2 = b;
		lst = LS_WORD;
		res_sel = 1'b0;
		cls = 0;
		e.rd_vld = 1'b1;
		case (kind)
			0: s.inst = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
			1:
			begin
				s.inst = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
				mode = ALU_SUB;
			end
			2:
			begin
				s.inst = {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
				mode = ALU_XOR;
			end
			3:
			begin
				s.inst = {i12, rs1, 3'b000, rd, 7'h13}; // addi
				op2 = imm;
			end
			4, 5:
			begin
				lst = (kind == 4) ? LS_HALF : LS_WORD;
				s.inst = {i12, rs1, lst, rd, 7'h03};
				e.itype[TYPE_LOAD] = 1'b1;
				cls = 1;
			end
			6, 7:
			begin
				lst = (kind == 6) ? LS_HALF : LS_WORD;
				s.inst = {i12[11:5], rs2, rs1, lst, i12[4:0], 7'h23};
				e.itype[TYPE_STORE] = 1'b1;
				e.rd_vld = 1'b0;
				e.brc = b; // store data
				e.chk_brc = 1'b1;
				cls = 1;
			end
			8:
			begin
				ofs = {{19{i12[11]}}, i12, 1'b0}; // beq
				s.inst = {ofs[12], ofs[10:5], rs2, rs1, 3'b000, ofs[4:1], ofs[11], 7'h63};
				mode = ALU_XOR; // equality compare
				e.itype[TYPE_B] = 1'b1;
				e.rd_vld = 1'b0;
				e.brc = s.pj ? s.pc + 32'd4 : s.pc + ofs;
				e.chk_brc = 1'b1;
			end
			9:
			begin
				rand_bits(20, r);
				ofs = {{11{r[19]}}, r[19:0], 1'b0};
				s.inst = {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, 7'h6F};
				op1 = s.pc;
				op2 = 32'd4;
				e.brc = s.pj ? s.pc + 32'd4 : s.pc + ofs;
				e.chk_brc = 1'b1;
			end
			10:
			begin
				s.inst = {i12, rs1, 3'b000, rd, 7'h67};
				op1 = s.pc;
				op2 = 32'd4;
				e.brc = s.pj ? s.pc + 32'd4 : ((a + imm) & ~32'd1);
				e.chk_brc = 1'b1;
			end
			11:
			begin
				s.inst = {i12, rs1, 3'b001, rd, 7'h73}; // csrrw
				e.itype[TYPE_CSR] = 1'b1;
				cls = 2;
			end
			12, 13, 14, 15:
			begin
				lst = (kind == 12) ? 3'b000 : (kind == 13) ? 3'b001 :
					(kind == 14) ? 3'b100 : 3'b110;
				s.inst = {7'h01, rs2, rs1, lst, rd, 7'h33};
				res_sel = kind == 13; // mulh high half
				if (kind <= 13)
					e.itype[TYPE_MUL] = 1'b1;
				else if (kind == 14)
					e.itype[TYPE_DIV] = 1'b1;
				else
					e.itype[TYPE_REM] = 1'b1;
				cls = 3;
			end
			default:
			begin
				s.inst = {i12, rs1, 3'b000, rd, 7'h7F}; // unknown opcode
				e.rd_vld = 1'b0;
				cls = 4;
			end
		endcase
		addr = a + imm;
		mis = (lst == LS_HALF) ? addr[0] : (addr[1:0] != 2'b00);
		case (cls)
			0:
			begin
				e.pl.alu.prdt_jump = s.pj;
				e.pl.alu.alu_mode = mode;
				e.pl.alu.op1 = op1;
				e.pl.alu.op2 = op2;
			end
			1:
			begin
				e.pl.ls.ls_type = lst;
				e.pl.ls.alu_mode = ALU_ADD;
				e.pl.ls.op1 = a;
				e.pl.ls.op2 = imm;
			end
			2:
			begin
				e.pl.csr.csr_addr = i12;
				e.pl.csr.upd_type = 2'b01; // write
				e.pl.csr.mask = a;
			end
			3:
			begin
				e.pl.md.op_a = {a[31], a}; // all four are signed
				e.pl.md.op_b = {b[31], b};
				e.pl.md.res_sel = res_sel;
			end
			default: e.pl.ill.inst = s.inst;
		endcase
		if (cls == 4)
			e.err = ERR_ILLEGAL;
		else if (s.err == IMEM_UNALIGNED)
			e.err = ERR_PC_UNALIGNED;
		else if (s.err != IMEM_OK)
			e.err = ERR_BUS;
		else if (cls == 1 && mis)
			e.err = e.itype[TYPE_STORE] ? ERR_ST_UNALIGNED : ERR_LD_UNALIGNED;
		stim_q.push_back(s);
		pend_q.push_back(e);
	endtask

	task automatic check_dispatch(input exp_t e);
		check_field("disp_payload", 160'(disp_payload), 160'(e.pl));
		check_field("disp_inst_type", 160'(disp_inst_type), 160'(e.itype));
		check_field("disp_pc", 160'(disp_pc), 160'(e.pc));
		check_field("disp_rd_vld", 160'(disp_rd_vld), 160'(e.rd_vld));
		check_field("disp_err_code", 160'(disp_err_code), 160'(e.err));
		if (e.chk_brc)
			check_field("disp_brc_pc_upd_store_din", 160'(disp_brc_pc_upd_store_din),
				160'(e.brc));
		if (e.rd_vld)
			check_field("disp_rd_id", 160'(disp_rd_id), 160'(e.rd_id));
	endtask

	initial
	begin
		logic [31:0] r;
		logic [159:0] snap;
		logic held;
		logic flushed;
		logic fetched;
		logic done;
		exp_t cur_exp;
		int cycle;
		resetn = 1'b0;
		flush_req = 1'b0;
		fetch_inst = '0;
		fetch_pc = '0;
		fetch_prdt_jump = 1'b0;
		fetch_imem_err = IMEM_OK;
		fetch_valid = 1'b0;
		wb_en = 1'b0;
		wb_rd_id = '0;
		wb_rd_v = '0;
		disp_ready = 1'b0;
		held = 1'b0;
		flushed = 1'b0;
		fetched = 1'b0;
		done = 1'b0;
		cycle = 0;
		snap = '0;
		cur_exp = '0;
		model_regs[0] = 32'd0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		// x0 gets a write too and must still read zero
		for (int i = 0; i < 32; i++)
		begin
			rand_bits(32, r);
			wb_en = 1'b1;
			wb_rd_id = i[4:0];
			wb_rd_v = r;
			if (i != 0)
				model_regs[i] = r;
			@(negedge clk);
		end
		wb_en = 1'b0;
		for (int i = 0; i < N_ITEMS; i++)
			make_item(i % 17, i);
		while (!done)
		begin
			@(negedge clk);
			cycle++;
			if (cycle > CYCLE_LIMIT)
				fail_now("timeout: dispatch queue did not drain");
			if (flushed)
				check_field("disp_valid", 160'(disp_valid), 160'd0);
			if (held)
			begin
				check_field("disp_valid", 160'(disp_valid), 160'd1);
				check_field("held disp fields", {disp_payload, disp_inst_type, disp_pc,
					disp_brc_pc_upd_store_din, disp_rd_id, disp_rd_vld, disp_err_code}, snap);
			end
			flushed = 1'b0;
			if (fetched)
				fetch_valid = 1'b0;
			fetched = 1'b0;
			if (!fetch_valid && stim_q.size() > 0)
			begin
				fetch_inst = stim_q[0].inst;
				fetch_pc = stim_q[0].pc;
				fetch_prdt_jump = stim_q[0].pj;
				fetch_imem_err = stim_q[0].err;
				fetch_valid = 1'b1;
				cur_exp = pend_q.pop_front();
				void'(stim_q.pop_front());
			end
			flush_req = (cycle == FLUSH_A) || (cycle == FLUSH_B);
			rand_bits(2, r);
			disp_ready = r[1:0] != 2'b00; // stall one cycle in four
			#1;
			held = disp_valid && !disp_ready && !flush_req;
			snap = {disp_payload, disp_inst_type, disp_pc, disp_brc_pc_upd_store_din,
				disp_rd_id, disp_rd_vld, disp_err_code};
			if (flush_req)
			begin
				exp_q.delete(); // in-flight work is dropped
				flushed = 1'b1;
			end
			else
			begin
				if (disp_valid && disp_ready)
				begin
					if (exp_q.size() == 0)
						fail_now("dispatch seen with no instruction in flight");
					check_dispatch(exp_q.pop_front());
				end
				if (fetch_valid && fetch_ready)
				begin
					exp_q.push_back(cur_exp);
					fetched = 1'b1;
				end
			end
			done = stim_q.size() == 0 && !fetch_valid && exp_q.size() == 0 &&
				cycle > FLUSH_B + 4;
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* decode_stage_top.f */
hw/decode_pkg.sv
hw/fetch_pre_decoder.sv
hw/gpr_file.sv
hw/inst_decoder.sv
hw/dispatch_msg_gen.sv
hw/decode_stage_top.sv
tests/tb_decode_stage.sv

/* Makefile */
# Verilator build and run for the decode stage

VERILATOR ?= verilator
FILELIST  ?= decode_stage_top.f
TB_TOP    ?= tb_decode_stage
RTL_TOP   ?= decode_stage_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
